/* rtl/la_defines.svh */
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// Wishbone bus widths
`define LA_WB_ADDR_W     8
`define LA_WB_DATA_W     32

// Capture datapath
`define LA_CHANNELS      9
`define LA_FIFO_W        18        // Two samples per word
`define LA_IO_COUNT      4
`define LA_USERIO_COUNT  8

// Register field widths
`define LA_TRIG_W        6
`define LA_GROUP_W       3
`define LA_DEPTH_W       32
`define LA_DS_W          16

// Register reset values
`define LA_TRIG_RESET    6'h00     // glitch_go
`define LA_GROUP_RESET   3'h0      // probe_a
`define LA_DEPTH_RESET   32'h0
`define LA_DS_RESET      16'h0

// Pattern generators
`define LA_RAMP_SEED     9'h1A0
`define LA_FILL_PATTERN  9'h155    // Channel 0 high, then alternating

// Register map
`define LA_ADDR_TRIGGER_SOURCE  8'h00
`define LA_ADDR_CAPTURE_GROUP   8'h04
`define LA_ADDR_STATUS          8'h08
`define LA_ADDR_CAPTURE_DEPTH   8'h0C
`define LA_ADDR_DOWNSAMPLE      8'h10
`define LA_ADDR_MANUAL_CAPTURE  8'h14
`define LA_ADDR_ARM             8'h18

`endif

/* rtl/la_reg_pkg.sv */
`include "la_defines.svh"

package la_reg_pkg;

   // Raw trigger source field, decoded in la_trigger
   typedef logic [`LA_TRIG_W-1:0]  trig_code_t;

   typedef logic [`LA_GROUP_W-1:0] group_t;        // Capture group code
   typedef logic [`LA_DEPTH_W-1:0] depth_t;        // Samples per capture
   typedef logic [`LA_DS_W-1:0]    downsample_t;   // Ratio minus one

   // Status word, read at LA_ADDR_STATUS
   typedef struct packed {
      logic capturing;   // Bit 1
      logic armed;       // Bit 0
   } status_t;

endpackage

/* rtl/la_capture_pkg.sv */
`include "la_defines.svh"

package la_capture_pkg;

   // Internal trigger codes
   localparam logic [2:0] TRIG_INT_GLITCH_GO      = 3'd0;
   localparam logic [2:0] TRIG_INT_CAPTURE_ACTIVE = 3'd1;

   // Three views of the 6-bit trigger source word
   typedef union packed {
      struct packed {
         logic [2:0] upper;     // Must be zero
         logic [2:0] code;
      } int_v;
      struct packed {
         logic       is_io;     // Bit 5 set
         logic       unused_4;
         logic       invert;
         logic       unused_2;
         logic [1:0] sel;       // io 0..3
      } io_v;
      struct packed {
         logic       is_io;     // Bit 5 clear
         logic       invert;
         logic       is_user;   // Bit 3 set
         logic [2:0] sel;       // userio 0..7
      } user_v;
   } trig_sel_u;

   typedef logic [`LA_CHANNELS-1:0] sample_t;    // All channels, one instant
   typedef logic [`LA_FIFO_W-1:0]   fifo_word_t; // Sample pair

   typedef enum logic [2:0] {
      GROUP_PROBE_A = 3'd0,
      GROUP_PROBE_B = 3'd1,
      GROUP_RAMP    = 3'd2   // Anything above gives the fill pattern
   } capture_group_e;

endpackage

/* rtl/la_regs.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_regs (
   input  logic                         observer_clk,
   input  logic                         reset,
   input  logic                         wb_cyc,
   input  logic                         wb_stb,
   input  logic                         wb_we,
   input  logic [`LA_WB_ADDR_W-1:0]     wb_adr,
   input  logic [`LA_WB_DATA_W-1:0]     wb_dat_w,
   output logic                         wb_ack,
   output logic [`LA_WB_DATA_W-1:0]     wb_dat_r,
   input  logic                         armed,
   input  logic                         capturing,
   output la_reg_pkg::trig_code_t       trig_code,
   output la_reg_pkg::group_t           capture_group,
   output la_reg_pkg::depth_t           capture_depth,
   output la_reg_pkg::downsample_t      downsample,
   output logic                         manual_capture,
   output logic                         arm_set
);

   logic                       wb_req;     // Request not yet acked
   logic                       wr_en;
   la_reg_pkg::status_t        status;
   logic [`LA_WB_DATA_W-1:0]   rd_data;

   assign wb_req  = wb_cyc & wb_stb & ~wb_ack;
   assign wr_en   = wb_req & wb_we;
   assign arm_set = wr_en && (wb_adr == `LA_ADDR_ARM) && wb_dat_w[0];

   assign status = '{capturing: capturing, armed: armed};

   // Single-cycle ack, one cycle after the request
   always_ff @(posedge observer_clk) begin
      if (reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= wb_req;
   end

   // Configuration registers, written at the ack edge
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_code      <= `LA_TRIG_RESET;
         capture_group  <= `LA_GROUP_RESET;
         capture_depth  <= `LA_DEPTH_RESET;
         downsample     <= `LA_DS_RESET;
         manual_capture <= 1'b0;
      end else if (wr_en) begin
         case (wb_adr)
            `LA_ADDR_TRIGGER_SOURCE: trig_code      <= wb_dat_w[`LA_TRIG_W-1:0];
            `LA_ADDR_CAPTURE_GROUP:  capture_group  <= wb_dat_w[`LA_GROUP_W-1:0];
            `LA_ADDR_CAPTURE_DEPTH:  capture_depth  <= wb_dat_w[`LA_DEPTH_W-1:0];
            `LA_ADDR_DOWNSAMPLE:     downsample     <= wb_dat_w[`LA_DS_W-1:0];
            `LA_ADDR_MANUAL_CAPTURE: manual_capture <= wb_dat_w[0];
            default: ;   // Status and arm have no storage here
         endcase
      end
   end

   always_comb begin
      rd_data = '0;   // Unmapped reads as zero
      case (wb_adr)
         `LA_ADDR_TRIGGER_SOURCE: rd_data[`LA_TRIG_W-1:0]     = trig_code;
         `LA_ADDR_CAPTURE_GROUP:  rd_data[`LA_GROUP_W-1:0]    = capture_group;
         `LA_ADDR_STATUS:         rd_data[$bits(status)-1:0]  = status;
         `LA_ADDR_CAPTURE_DEPTH:  rd_data[`LA_DEPTH_W-1:0]    = capture_depth;
         `LA_ADDR_DOWNSAMPLE:     rd_data[`LA_DS_W-1:0]       = downsample;
         `LA_ADDR_MANUAL_CAPTURE: rd_data[0]                  = manual_capture;
         `LA_ADDR_ARM:            rd_data[0]                  = armed;
         default: ;
      endcase
   end

   // Read data lines up with ack
   always_ff @(posedge observer_clk) begin
      if (wb_req)
         wb_dat_r <= rd_data;
   end

endmodule

/* rtl/la_trigger.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_trigger (
   input  logic                          observer_clk,
   input  logic                          reset,
   input  la_reg_pkg::trig_code_t        trig_code,
   input  logic                          manual_capture,
   input  logic                          arm_set,
   input  logic                          capturing,
   input  logic [`LA_IO_COUNT-1:0]       io,
   input  logic [`LA_USERIO_COUNT-1:0]   userio,
   input  logic                          glitch_go,
   input  logic                          capture_active,
   output logic                          capture_go,
   output logic                          armed
);

   la_capture_pkg::trig_sel_u sel;
   logic       trig_src;
   logic       trig_async;
   logic [1:0] sync_q;        // Two-stage synchronizer
   logic       trig_d;        // Previous synchronized level

   assign sel = trig_code;

   always_comb begin
      trig_src = 1'b0;   // Unused codes never trigger
      if (sel.io_v.is_io)
         trig_src = io[sel.io_v.sel] ^ sel.io_v.invert;
      else if (sel.user_v.is_user)
         trig_src = userio[sel.user_v.sel] ^ sel.user_v.invert;
      else if (sel.int_v.upper == 3'b000) begin
         case (sel.int_v.code)
            la_capture_pkg::TRIG_INT_GLITCH_GO:      trig_src = glitch_go;
            la_capture_pkg::TRIG_INT_CAPTURE_ACTIVE: trig_src = capture_active;
            default:                                 trig_src = 1'b0;
         endcase
      end
   end

   assign trig_async = trig_src | manual_capture;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_q     <= 2'b00;
         trig_d     <= 1'b0;
         capture_go <= 1'b0;
      end else begin
         sync_q     <= {sync_q[0], trig_async};
         trig_d     <= sync_q[1];
         // Rising edge, only when armed and idle
         capture_go <= sync_q[1] & ~trig_d & armed & ~capturing;
      end
   end

   // Armed until the capture actually starts
   always_ff @(posedge observer_clk) begin
      if (reset)
         armed <= 1'b0;
      else if (capturing)
         armed <= 1'b0;
      else if (arm_set)
         armed <= 1'b1;
   end

endmodule

/* rtl/la_capture.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module la_capture (
   input  logic                         observer_clk,
   input  logic                         reset,
   input  logic                         capture_go,
   input  la_reg_pkg::group_t           capture_group,
   input  la_reg_pkg::depth_t           capture_depth,
   input  la_reg_pkg::downsample_t      downsample,
   input  la_capture_pkg::sample_t      probe_a,
   input  la_capture_pkg::sample_t      probe_b,
   output logic                         capturing,
   output logic                         fifo_wr,
   output la_capture_pkg::fifo_word_t   fifo_wr_data,
   output logic                         capture_start,
   output logic                         capture_done
);

   la_capture_pkg::sample_t              sample_q;   // Selected group
   la_capture_pkg::sample_t              ramp;
   logic [`LA_CHANNELS-1:0][1:0]         chan_sr;    // [1] older, [0] newer
   la_reg_pkg::downsample_t              ds_ctr;
   logic                                 tick;
   logic                                 pair_phase; // High on second sample
   la_reg_pkg::depth_t                   sample_cnt;
   logic                                 capturing_q;

   always_ff @(posedge observer_clk) begin
      case (capture_group)
         la_capture_pkg::GROUP_PROBE_A: sample_q <= probe_a;
         la_capture_pkg::GROUP_PROBE_B: sample_q <= probe_b;
         la_capture_pkg::GROUP_RAMP:    sample_q <= ramp;
         default:                       sample_q <= `LA_FILL_PATTERN;
      endcase
   end

   // Self-test ramp, restarted by each capture
   always_ff @(posedge observer_clk) begin
      if (reset || capture_go)
         ramp <= `LA_RAMP_SEED;
      else
         ramp <= ramp + 1'b1;
   end

   // Downsample tick every downsample+1 cycles
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ds_ctr <= '0;
         tick   <= 1'b0;
      end else if (capture_go) begin
         ds_ctr <= '0;
         tick   <= 1'b0;
      end else if (ds_ctr == downsample) begin
         ds_ctr <= '0;
         tick   <= 1'b1;
      end else begin
         ds_ctr <= ds_ctr + 1'b1;
         tick   <= 1'b0;
      end
   end

   always_ff @(posedge observer_clk) begin
      if (capturing && tick) begin
         for (int k = 0; k < `LA_CHANNELS; k++)
            chan_sr[k] <= {chan_sr[k][0], sample_q[k]};
      end
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing   <= 1'b0;
         capturing_q <= 1'b0;
         fifo_wr     <= 1'b0;
         pair_phase  <= 1'b0;
         sample_cnt  <= '0;
      end else begin
         capturing_q <= capturing;
         fifo_wr     <= 1'b0;
         if (capture_go) begin
            capturing  <= 1'b1;
            pair_phase <= 1'b0;
            sample_cnt <= '0;
         end else if (capturing && tick) begin
            pair_phase <= ~pair_phase;
            fifo_wr    <= pair_phase;   // Pair complete
            sample_cnt <= sample_cnt + 1'b1;
            if (sample_cnt == capture_depth - 1'b1)
               capturing <= 1'b0;      // Last sample taken
         end
      end
   end

   // Ramp group packs whole samples so the count reads directly
   always_comb begin
      fifo_wr_data = chan_sr;
      if (capture_group == la_capture_pkg::GROUP_RAMP) begin
         for (int k = 0; k < `LA_CHANNELS; k++) begin
            fifo_wr_data[`LA_CHANNELS + k] = chan_sr[k][1];
            fifo_wr_data[k]                = chan_sr[k][0];
         end
      end
   end

   assign capture_start = capturing & ~capturing_q;
   assign capture_done  = capturing_q & ~capturing;

endmodule

/* rtl/logic_analyzer.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module logic_analyzer (
   input  logic                          observer_clk,
   input  logic                          reset,
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [`LA_WB_ADDR_W-1:0]      wb_adr,
   input  logic [`LA_WB_DATA_W-1:0]      wb_dat_w,
   output logic                          wb_ack,
   output logic [`LA_WB_DATA_W-1:0]      wb_dat_r,
   input  la_capture_pkg::sample_t       probe_a,
   input  la_capture_pkg::sample_t       probe_b,
   input  logic [`LA_IO_COUNT-1:0]       io,
   input  logic [`LA_USERIO_COUNT-1:0]   userio,
   input  logic                          glitch_go,
   input  logic                          capture_active,
   output logic                          fifo_wr,
   output la_capture_pkg::fifo_word_t    fifo_wr_data,
   output logic                          capture_start,
   output logic                          capture_done
);

   la_reg_pkg::trig_code_t    trig_code;
   la_reg_pkg::group_t        capture_group;
   la_reg_pkg::depth_t        capture_depth;
   la_reg_pkg::downsample_t   downsample;
   logic                      manual_capture;
   logic                      arm_set;
   logic                      armed;
   logic                      capture_go;
   logic                      capturing;

   la_regs u_regs (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .wb_cyc         (wb_cyc),
      .wb_stb         (wb_stb),
      .wb_we          (wb_we),
      .wb_adr         (wb_adr),
      .wb_dat_w       (wb_dat_w),
      .wb_ack         (wb_ack),
      .wb_dat_r       (wb_dat_r),
      .armed          (armed),
      .capturing      (capturing),
      .trig_code      (trig_code),
      .capture_group  (capture_group),
      .capture_depth  (capture_depth),
      .downsample     (downsample),
      .manual_capture (manual_capture),
      .arm_set        (arm_set)
   );

   la_trigger u_trigger (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .trig_code      (trig_code),
      .manual_capture (manual_capture),
      .arm_set        (arm_set),
      .capturing      (capturing),
      .io             (io),
      .userio         (userio),
      .glitch_go      (glitch_go),
      .capture_active (capture_active),
      .capture_go     (capture_go),
      .armed          (armed)
   );

   la_capture u_capture (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .capture_go     (capture_go),
      .capture_group  (capture_group),
      .capture_depth  (capture_depth),
      .downsample     (downsample),
      .probe_a        (probe_a),
      .probe_b        (probe_b),
      .capturing      (capturing),
      .fifo_wr        (fifo_wr),
      .fifo_wr_data   (fifo_wr_data),
      .capture_start  (capture_start),
      .capture_done   (capture_done)
   );

endmodule

/* tb/la_props.sv */
`timescale 1ns/1ps

module la_props (
   input logic observer_clk,
   input logic reset,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic capturing,
   input logic capture_start,
   input logic capture_done,
   input logic fifo_wr
);

   // One-cycle ack, only in answer to a request
   ack_single: assert property (@(posedge observer_clk) disable iff (reset)
      wb_ack |=> !wb_ack) else $error("wb_ack high on two consecutive cycles");
   ack_after_req: assert property (@(posedge observer_clk) disable iff (reset)
      wb_ack |-> $past(wb_cyc && wb_stb)) else $error("wb_ack without a request");

   start_done_excl: assert property (@(posedge observer_clk) disable iff (reset)
      !(capture_start && capture_done)) else $error("capture_start and capture_done together");

   // Last write lands in the cycle capturing falls
   wr_in_capture: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr |-> (capturing || $past(capturing))) else $error("fifo_wr outside a capture");

endmodule

bind la_regs la_props u_regs_props (
   .observer_clk  (observer_clk),
   .reset         (reset),
   .wb_cyc        (wb_cyc),
   .wb_stb        (wb_stb),
   .wb_ack        (wb_ack),
   .capturing     (capturing),
   .capture_start (1'b0),
   .capture_done  (1'b0),
   .fifo_wr       (1'b0)
);

bind la_capture la_props u_capture_props (
   .observer_clk  (observer_clk),
   .reset         (reset),
   .wb_cyc        (1'b0),
   .wb_stb        (1'b0),
   .wb_ack        (1'b0),
   .capturing     (capturing),
   .capture_start (capture_start),
   .capture_done  (capture_done),
   .fifo_wr       (fifo_wr)
);

/* tb/tb_logic_analyzer.sv */
`timescale 1ns/1ps
`include "la_defines.svh"

module tb_logic_analyzer;

   localparam int NUM_ROWS = 7;
   localparam int IO_PIN   = 2;
   localparam int USER_PIN = 5;

   // Which input starts the capture
   localparam logic [2:0] TG_MANUAL    = 3'd0;
   localparam logic [2:0] TG_IO_FALL   = 3'd1;
   localparam logic [2:0] TG_USER_RISE = 3'd2;
   localparam logic [2:0] TG_NO_ARM    = 3'd3;   // userio rise without an arm write
   localparam logic [2:0] TG_IO_TWICE  = 3'd4;   // Second edge mid-capture

   localparam logic [1:0] RULE_PROBE_A = 2'd0;
   localparam logic [1:0] RULE_PROBE_B = 2'd1;
   localparam logic [1:0] RULE_RAMP    = 2'd2;
   localparam logic [1:0] RULE_FILL    = 2'd3;

   typedef struct packed {
      logic [5:0]  code;
      logic [2:0]  group;
      logic [31:0] depth;
      logic [15:0] ds;
      logic [8:0]  probe;
      logic [2:0]  toggle;
      logic [7:0]  count;   // Expected FIFO words
      logic [1:0]  rule;
   } row_t;

   logic        observer_clk = 1'b0;
   logic        reset;
   logic        wb_cyc, wb_stb, wb_we;
   logic [7:0]  wb_adr;
   logic [31:0] wb_dat_w, wb_dat_r;
   logic        wb_ack;
   logic [8:0]  probe_a, probe_b;
   logic [3:0]  io;
   logic [7:0]  userio;
   logic        glitch_go, capture_active;
   logic        fifo_wr, capture_start, capture_done;
   logic [17:0] fifo_wr_data;

   row_t        rows [NUM_ROWS];
   logic [17:0] words [$];
   int          starts = 0;
   int          dones = 0;
   int          acks = 0;
   int          accesses = 0;
   int          cycles = 0;
   int          cycle_limit = 0;

   logic_analyzer DUT (.*);

   always #10 observer_clk = ~observer_clk;

   always @(posedge observer_clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout: run exceeded %0d cycles without finishing", cycle_limit);
         $display("Test failed");
         $fatal(1);
      end
   end

   // FIFO and pulse monitor on the falling edge
   always @(negedge observer_clk) begin
      if (!reset) begin
         if (fifo_wr) words.push_back(fifo_wr_data);
         if (capture_start) starts++;
         if (capture_done) dones++;
         if (wb_ack) acks++;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                  $time, name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic wb_access(input logic we, input logic [7:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      @(posedge observer_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      @(negedge observer_clk);
      while (!wb_ack) @(negedge observer_clk);
      rdat = wb_dat_r;
      accesses++;
      @(posedge observer_clk);
      wb_cyc <= 1'b0;   // Request ends right after the ack
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdat);
      logic [31:0] unused_rd;
      wb_access(1'b1, adr, wdat, unused_rd);
   endtask

   task automatic read_expect(input string name, input logic [7:0] adr,
                              input logic [31:0] exp);
      logic [31:0] rd;
      wb_access(1'b0, adr, 32'h0, rd);
      check_value(name, rd, exp);
   endtask

   // Both bits of channel k carry bit k of the sample
   function automatic logic [17:0] paired_word(input logic [8:0] s);
      logic [17:0] w;
      for (int k = 0; k < `LA_CHANNELS; k++) begin
         w[2*k+1] = s[k];
         w[2*k]   = s[k];
      end
      return w;
   endfunction

   function automatic logic [8:0] expected_sample(input row_t r);
      case (r.rule)
         RULE_PROBE_B: return ~r.probe;
         RULE_FILL:    return `LA_FILL_PATTERN;
         default:      return r.probe;
      endcase
   endfunction

   task automatic check_words(input row_t r, input int base);
      logic [17:0] w;
      logic [8:0]  step;
      logic [8:0]  exp_half;
      logic [8:0]  prev_newer;
      step = 9'(r.ds + 16'd1);
      prev_newer = '0;
      for (int n = base; n < words.size(); n++) begin
         w = words[n];
         if (r.rule == RULE_RAMP) begin
            exp_half = w[17:9] + step;   // Wraps at 512
            check_value("ramp newer half", 32'(w[8:0]), 32'(exp_half));
            exp_half = prev_newer + step;
            if (n > base)
               check_value("ramp older half", 32'(w[17:9]), 32'(exp_half));
            prev_newer = w[8:0];
         end else begin
            check_value("fifo_wr_data", 32'(w), 32'(paired_word(expected_sample(r))));
         end
      end
   endtask

   task automatic run_row(input int i);
      row_t r;
      int   base_words;
      int   base_starts;
      int   base_dones;
      int   exp_pulses;
      r = rows[i];
      wb_write(`LA_ADDR_TRIGGER_SOURCE, 32'(r.code));
      wb_write(`LA_ADDR_CAPTURE_GROUP, 32'(r.group));
      wb_write(`LA_ADDR_CAPTURE_DEPTH, r.depth);
      wb_write(`LA_ADDR_DOWNSAMPLE, 32'(r.ds));
      @(posedge observer_clk);
      probe_a <= r.probe;
      probe_b <= ~r.probe;
      base_words  = words.size();
      base_starts = starts;
      base_dones  = dones;
      exp_pulses  = (r.toggle == TG_NO_ARM) ? 0 : 1;
      if (r.toggle != TG_NO_ARM) begin
         wb_write(`LA_ADDR_ARM, 32'h1);
         read_expect("arm readback", `LA_ADDR_ARM, 32'h1);
      end
      if (r.toggle == TG_MANUAL) begin
         wb_write(`LA_ADDR_MANUAL_CAPTURE, 32'h1);
      end else begin
         @(posedge observer_clk);
         if (r.toggle == TG_USER_RISE || r.toggle == TG_NO_ARM)
            userio[USER_PIN] <= 1'b1;
         else
            io[IO_PIN] <= 1'b0;   // Inverted source triggers on the fall
      end
      if (r.toggle == TG_NO_ARM) begin
         repeat (40) @(posedge observer_clk);
      end else begin
         if (r.toggle == TG_IO_TWICE) begin
            while (starts == base_starts) @(posedge observer_clk);
            repeat (4) @(posedge observer_clk);
            io[IO_PIN] <= 1'b1;
            repeat (4) @(posedge observer_clk);
            io[IO_PIN] <= 1'b0;
         end
         while (dones == base_dones) @(posedge observer_clk);
         repeat (4) @(posedge observer_clk);   // Catch any stray writes
      end
      check_value("fifo word count", 32'(words.size() - base_words), 32'(r.count));
      check_value("capture_start count", 32'(starts - base_starts), 32'(exp_pulses));
      check_value("capture_done count", 32'(dones - base_dones), 32'(exp_pulses));
      check_words(r, base_words);
      @(posedge observer_clk);
      io     <= 4'hF;
      userio <= 8'h00;
      if (r.toggle == TG_MANUAL) wb_write(`LA_ADDR_MANUAL_CAPTURE, 32'h0);
      read_expect("status after capture", `LA_ADDR_STATUS, 32'h0);
   endtask

   initial begin
      void'($urandom(59804));
      reset          <= 1'b1;
      wb_cyc         <= 1'b0;
      wb_stb         <= 1'b0;
      wb_we          <= 1'b0;
      wb_adr         <= 8'h00;
      wb_dat_w       <= 32'h0;
      probe_a        <= 9'h000;
      probe_b        <= 9'h000;
      io             <= 4'hF;   // Idle high for the inverted io trigger
      userio         <= 8'h00;
      glitch_go      <= 1'b0;
      capture_active <= 1'b0;

      //          code   grp    depth   ds      probe   toggle        words  rule
      rows[0] = '{6'h00, 3'd0, 32'd8,  16'd0, 9'h000, TG_MANUAL,    8'd4, RULE_PROBE_A};
      rows[1] = '{6'h00, 3'd1, 32'd6,  16'd2, 9'h000, TG_MANUAL,    8'd3, RULE_PROBE_B};
      rows[2] = '{6'h00, 3'd2, 32'd10, 16'd0, 9'h000, TG_MANUAL,    8'd5, RULE_RAMP};
      rows[3] = '{6'h2A, 3'd5, 32'd8,  16'd1, 9'h000, TG_IO_FALL,   8'd4, RULE_FILL};
      rows[4] = '{6'h0D, 3'd0, 32'd6,  16'd0, 9'h000, TG_USER_RISE, 8'd3, RULE_PROBE_A};
      rows[5] = '{6'h0D, 3'd0, 32'd8,  16'd0, 9'h000, TG_NO_ARM,    8'd0, RULE_PROBE_A};
      rows[6] = '{6'h2A, 3'd2, 32'd16, 16'd3, 9'h000, TG_IO_TWICE,  8'd8, RULE_RAMP};
      for (int i = 0; i < NUM_ROWS; i++) begin
         rows[i].probe = 9'($urandom);
         cycle_limit += int'(rows[i].depth) * (int'(rows[i].ds) + 1) + 200;
      end

      repeat (10) @(posedge observer_clk);
      reset <= 1'b0;

      // Register defaults after reset plus one unmapped address
      read_expect("trigger source", `LA_ADDR_TRIGGER_SOURCE, 32'h0);
      read_expect("capture group", `LA_ADDR_CAPTURE_GROUP, 32'h0);
      read_expect("status", `LA_ADDR_STATUS, 32'h0);
      read_expect("capture depth", `LA_ADDR_CAPTURE_DEPTH, 32'h0);
      read_expect("downsample", `LA_ADDR_DOWNSAMPLE, 32'h0);
      read_expect("manual capture", `LA_ADDR_MANUAL_CAPTURE, 32'h0);
      read_expect("arm", `LA_ADDR_ARM, 32'h0);
      read_expect("unmapped", 8'h1C, 32'h0);

      // Field masking
      wb_write(`LA_ADDR_TRIGGER_SOURCE, 32'hFFFF_FFFF);
      read_expect("trigger source", `LA_ADDR_TRIGGER_SOURCE, 32'h3F);
      wb_write(`LA_ADDR_CAPTURE_GROUP, 32'hFFFF_FFFF);
      read_expect("capture group", `LA_ADDR_CAPTURE_GROUP, 32'h7);
      wb_write(`LA_ADDR_CAPTURE_DEPTH, 32'hFFFF_FFFF);
      read_expect("capture depth", `LA_ADDR_CAPTURE_DEPTH, 32'hFFFF_FFFF);
      wb_write(`LA_ADDR_DOWNSAMPLE, 32'hFFFF_FFFF);
      read_expect("downsample", `LA_ADDR_DOWNSAMPLE, 32'h0000_FFFF);
      wb_write(8'h1C, 32'hFFFF_FFFF);
      read_expect("unmapped", 8'h1C, 32'h0);
      check_value("wb_ack count", 32'(acks), 32'(accesses));

      for (int i = 0; i < NUM_ROWS; i++)
         run_row(i);

      repeat (2) @(posedge observer_clk);
      check_value("wb_ack count", 32'(acks), 32'(accesses));
      $display("Test completed successfully");
      $finish;
   end

endmodule

/* project.f */
+incdir+rtl
rtl/la_reg_pkg.sv
rtl/la_capture_pkg.sv
rtl/la_regs.sv
rtl/la_trigger.sv
rtl/la_capture.sv
rtl/logic_analyzer.sv
tb/la_props.sv
tb/tb_logic_analyzer.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the logic analyzer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_logic_analyzer \
   -f project.f -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
